/* hdl/baseline_top.sv */
`timescale 1ns/1ps

module baseline_top (
   input  logic                                clk,
   input  logic                                rst,
   input  stream_pkg::sample_in_t              in,
   output stream_pkg::result_t                 out,
   output logic [dsp_cfg_pkg::COUNT_WIDTH-1:0] pulse_count
);

   import stream_pkg::*;

   // Running window sum with its sample, one edge after acceptance
   sum_stage_t stage;

   // First stage tracks the sum of the last WINDOW accepted samples
   moving_sum moving_sum_i (
      .clk   (clk),
      .rst   (rst),
      .in    (in),
      .stage (stage)
   );

   // Second stage turns the sum into baseline, residual and pulse decisions
   // Results appear two edges after the sample was presented
   pulse_detector pulse_detector_i (
      .clk         (clk),
      .rst         (rst),
      .stage       (stage),
      .out         (out),
      .pulse_count (pulse_count)
   );

endmodule

/* hdl/delay.sv */
`timescale 1ns/1ps

module delay #(
   parameter int CYCLES = 16,
   parameter int WIDTH  = 8
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             en,
   input  logic [WIDTH-1:0] in,
   output logic [WIDTH-1:0] out
);

   // Shift chain, stage 0 takes the new word and the last stage feeds the output
   logic [WIDTH-1:0] regs [CYCLES];

   // The chain only advances on enabled edges, so the delay is counted in
   // accepted words and not in clock cycles
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < CYCLES; i++) begin
            regs[i] <= '0;
         end
      end else if (en) begin
         regs[0] <= in;
         for (int i = 1; i < CYCLES; i++) begin
            regs[i] <= regs[i-1];
         end
      end
   end

   // Between enabled edges this is the word that entered CYCLES enables ago,
   // which is the one that leaves a CYCLES-long window on the next enable
   assign out = regs[CYCLES-1];

endmodule

/* hdl/dsp_cfg_pkg.sv */
package dsp_cfg_pkg;

   // Width of one unsigned input sample
   localparam int SAMPLE_WIDTH = 12;

   // Number of samples averaged for the baseline, kept a power of two
   // so that the division reduces to a right shift
   localparam int WINDOW      = 16;
   localparam int WINDOW_LOG2 = 4;

   // The running sum needs WINDOW_LOG2 extra bits to hold WINDOW full-scale samples
   localparam int SUM_WIDTH = SAMPLE_WIDTH + WINDOW_LOG2;

   // Residual is signed and spans the full sample range in both directions
   localparam int RESID_WIDTH = SAMPLE_WIDTH + 1;

   // A residual must be strictly greater than this level to count as a pulse
   localparam int THRESHOLD = 200;

   // Accepted samples after a pulse during which no new pulse is flagged
   localparam int HOLDOFF = 8;

   // Width of the saturating pulse counter
   localparam int COUNT_WIDTH = 16;

endpackage

/* hdl/moving_sum.sv */
`timescale 1ns/1ps

module moving_sum (
   input  logic                   clk,
   input  logic                   rst,
   input  stream_pkg::sample_in_t in,
   output stream_pkg::sum_stage_t stage
);

   import dsp_cfg_pkg::*;

   logic [SAMPLE_WIDTH-1:0] retired;
   logic [SUM_WIDTH-1:0]    sum_q;
   logic [SUM_WIDTH-1:0]    sum_next;
   logic [SAMPLE_WIDTH-1:0] sample_q;
   logic                    valid_q;

   // Window history
   // Its output is the sample that drops out of the window when the next
   // sample is accepted, and zero until WINDOW samples have been seen
   delay #(
      .CYCLES (WINDOW),
      .WIDTH  (SAMPLE_WIDTH)
   ) window_delay_i (
      .clk (clk),
      .rst (rst),
      .en  (in.valid),
      .in  (in.data),
      .out (retired)
   );

   // Add the newest sample and drop the oldest one
   // The sum never exceeds WINDOW full-scale samples, so SUM_WIDTH cannot overflow
   always_comb begin
      sum_next = sum_q + SUM_WIDTH'(in.data) - SUM_WIDTH'(retired);
   end

   // Accumulator and strobe
   // The strobe follows the input strobe by one edge, giving one cycle per sample
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         sum_q   <= '0;
         valid_q <= 1'b0;
      end else begin
         valid_q <= in.valid;
         if (in.valid) begin
            sum_q <= sum_next;
         end
      end
   end

   // Sample that matches the registered sum
   always_ff @(posedge clk) begin
      if (in.valid) begin
         sample_q <= in.data;
      end
   end

   assign stage = '{
      valid:  valid_q,
      sample: sample_q,
      sum:    sum_q
   };

endmodule

/* hdl/pulse_detector.sv */
`timescale 1ns/1ps

module pulse_detector (
   input  logic                                clk,
   input  logic                                rst,
   input  stream_pkg::sum_stage_t              stage,
   output stream_pkg::result_t                 out,
   output logic [dsp_cfg_pkg::COUNT_WIDTH-1:0] pulse_count
);

   import dsp_cfg_pkg::*;

   logic [SAMPLE_WIDTH-1:0]         baseline_next;
   logic signed [RESID_WIDTH-1:0]   residual_next;
   logic                            detect;

   logic [$clog2(HOLDOFF+1)-1:0]    holdoff_q;
   logic                            valid_q;
   logic                            pulse_q;
   logic [SAMPLE_WIDTH-1:0]         baseline_q;
   logic signed [RESID_WIDTH-1:0]   residual_q;

   // Baseline is the window average
   // WINDOW is a power of two, so the shift drops exactly WINDOW_LOG2 bits and
   // the average always fits back into a sample
   always_comb begin
      baseline_next = SAMPLE_WIDTH'(stage.sum >> WINDOW_LOG2);
   end

   // Both operands are zero-extended by one bit before the signed subtraction
   always_comb begin
      residual_next = $signed({1'b0, stage.sample}) - $signed({1'b0, baseline_next});
   end

   // A pulse needs a large enough residual and an expired hold-off
   always_comb begin
      detect = stage.valid && (residual_next > THRESHOLD) && (holdoff_q == '0);
   end

   // Hold-off counter
   // A pulse reloads it, and every later result while it is nonzero counts it down
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         holdoff_q <= '0;
      end else if (stage.valid) begin
         if (detect) begin
            holdoff_q <= ($clog2(HOLDOFF+1))'(HOLDOFF);
         end else if (holdoff_q != '0) begin
            holdoff_q <= holdoff_q - 1'b1;
         end
      end
   end

   // Saturating pulse counter, updated on the same edge as the result
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pulse_count <= '0;
      end else if (detect && (pulse_count != '1)) begin
         pulse_count <= pulse_count + 1'b1;
      end
   end

   // Output strobe and flag
   // The flag is only ever high together with the strobe
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_q <= 1'b0;
         pulse_q <= 1'b0;
      end else begin
         valid_q <= stage.valid;
         pulse_q <= detect;
      end
   end

   // Result payload, qualified by the output strobe
   always_ff @(posedge clk) begin
      if (stage.valid) begin
         baseline_q <= baseline_next;
         residual_q <= residual_next;
      end
   end

   assign out = '{
      valid:    valid_q,
      baseline: baseline_q,
      residual: residual_q,
      pulse:    pulse_q
   };

endmodule

/* hdl/stream_pkg.sv */
package stream_pkg;

   // Raw sample stream entering the design
   // A sample is taken on every rising clock edge where valid is high
   typedef struct packed {
      logic                                 valid;
      logic [dsp_cfg_pkg::SAMPLE_WIDTH-1:0] data;
   } sample_in_t;

   // Output of the moving sum stage
   // Sum already includes the sample carried alongside it
   typedef struct packed {
      logic                                 valid;
      logic [dsp_cfg_pkg::SAMPLE_WIDTH-1:0] sample;
      logic [dsp_cfg_pkg::SUM_WIDTH-1:0]    sum;
   } sum_stage_t;

   // Per-sample result of the detector
   // Residual is the sample minus the baseline, so it can go negative
   typedef struct packed {
      logic                                        valid;
      logic [dsp_cfg_pkg::SAMPLE_WIDTH-1:0]        baseline;
      logic signed [dsp_cfg_pkg::RESID_WIDTH-1:0]  residual;
      logic                                        pulse;
   } result_t;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the baseline detector testbench with Verilator and runs it.
# The run counts as passed only if the simulation log holds the pass message.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
OBJ_DIR=obj_dir
SIM_BIN=baseline_sim

verilator --binary --timing -Wno-fatal \
   -f src.f \
   --top-module baseline_tb \
   -Mdir "$OBJ_DIR" \
   -o "$SIM_BIN" > "$BUILD_LOG" 2>&1 \
   || { echo "build failed, see $BUILD_LOG"; tail -n 40 "$BUILD_LOG"; exit 1; }

./"$OBJ_DIR"/"$SIM_BIN" > "$SIM_LOG" 2>&1 \
   || echo "simulator returned a nonzero status"

cat "$SIM_LOG"

grep -qx "all tests passed" "$SIM_LOG" \
   && { echo "RESULT: PASS"; exit 0; } \
   || { echo "RESULT: FAIL"; exit 1; }

/* src.f */
+incdir+testbench
hdl/dsp_cfg_pkg.sv
hdl/stream_pkg.sv
hdl/delay.sv
hdl/moving_sum.sv
hdl/pulse_detector.sv
hdl/baseline_top.sv
testbench/baseline_tb.sv

/* testbench/baseline_model.svh */
`ifndef BASELINE_MODEL_SVH
`define BASELINE_MODEL_SVH

// Accepted samples inside the current window, oldest first
logic [SAMPLE_WIDTH-1:0] model_history [$];

// Samples left in the hold-off span after the last predicted pulse
int model_holdoff = 0;

// Predicted pulse count after the latest accepted sample
logic [COUNT_WIDTH-1:0] model_count = '0;

// Forget all history, as a reset of the DUT does
function automatic void reset_model();
   model_history.delete();
   model_holdoff = 0;
   model_count = '0;
endfunction

// Expected result for one newly accepted sample
// The model state advances by exactly one sample per call
function automatic result_t predict_result(input logic [SAMPLE_WIDTH-1:0] sample);
   result_t res;
   int window_sum;
   int base;
   int resid;
   model_history.push_back(sample);
   if (model_history.size() > WINDOW) begin
      void'(model_history.pop_front());
   end
   // Fewer than WINDOW samples since reset means the missing ones count as zero
   window_sum = 0;
   foreach (model_history[i]) begin
      window_sum += int'(model_history[i]);
   end
   base = window_sum / WINDOW;
   resid = int'(sample) - base;
   res.valid = 1'b1;
   res.baseline = SAMPLE_WIDTH'(base);
   res.residual = RESID_WIDTH'(resid);
   res.pulse = (resid > THRESHOLD) && (model_holdoff == 0);
   if (res.pulse) begin
      model_holdoff = HOLDOFF;
      if (model_count != '1) begin
         model_count = model_count + COUNT_WIDTH'(1);
      end
   end else if (model_holdoff > 0) begin
      model_holdoff = model_holdoff - 1;
   end
   return res;
endfunction

`endif

/* testbench/baseline_tb.sv */
`timescale 1ns/1ps

module baseline_tb;

   import dsp_cfg_pkg::*;
   import stream_pkg::*;

   localparam int CLK_PERIOD  = 40;
   localparam int NUM_SAMPLES = 400;
   localparam int GAP_PCT     = 30;
   localparam int MAX_GAP     = 4;
   localparam int RAMP_STEP   = 100;
   localparam int QUIET_LEVEL = 500;
   localparam int SPIKE_AMP   = 600;
   localparam int DRAIN_LIMIT = 8;

   // Upper bound on the run length, with every sample preceded by the longest gap
   localparam longint TIMEOUT_NS = (3 * NUM_SAMPLES * (MAX_GAP + 1) + 500) * CLK_PERIOD;

   // One predicted result together with the pulse count that goes with it
   typedef struct packed {
      result_t                res;
      logic [COUNT_WIDTH-1:0] count;
   } expect_t;

   logic                   clk = 1'b0;
   logic                   rst;
   sample_in_t             in;
   result_t                out;
   logic [COUNT_WIDTH-1:0] pulse_count;

   expect_t exp_q [$];
   int      errors = 0;
   int      accepted_count = 0;
   int      result_count = 0;
   int      seed = 64;

   `include "baseline_model.svh"

   baseline_top dut_i (
      .clk         (clk),
      .rst         (rst),
      .in          (in),
      .out         (out),
      .pulse_count (pulse_count)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("mismatch %s expected %h actual %h at %0t", name, expected, actual, $time);
         errors++;
      end
   endtask

   function automatic logic [SAMPLE_WIDTH-1:0] random_sample();
      return SAMPLE_WIDTH'($random(seed));
   endfunction

   // Present one sample and record what the DUT must answer
   task automatic send_sample(input logic [SAMPLE_WIDTH-1:0] data);
      expect_t e;
      @(posedge clk);
      in <= '{valid: 1'b1, data: data};
      e.res = predict_result(data);
      e.count = model_count;
      exp_q.push_back(e);
      accepted_count++;
   endtask

   // Random data on idle cycles shows that only valid samples move the state
   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         in <= '{valid: 1'b0, data: random_sample()};
      end
   endtask

   // Results come two edges after their sample, so a short bounded wait covers them all
   task automatic drain_results();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
         idle_cycles(1);
         waited++;
      end
      idle_cycles(3);
      if (exp_q.size() != 0) begin
         $display("error: %0d expected results never arrived", exp_q.size());
         errors++;
         exp_q.delete();
      end
   endtask

   task automatic apply_reset();
      @(posedge clk);
      rst <= 1'b1;
      in <= '{valid: 1'b0, data: '0};
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      reset_model();
   endtask

   task automatic send_ramp();
      for (int i = 0; i < WINDOW; i++) begin
         send_sample(SAMPLE_WIDTH'((i + 1) * RAMP_STEP));
      end
   endtask

   // Spacings up to twice HOLDOFF put some spikes inside an earlier hold-off span
   task automatic send_spikes(input int count);
      int spacing;
      spacing = 0;
      for (int i = 0; i < count; i++) begin
         if (spacing == 0) begin
            send_sample(SAMPLE_WIDTH'(QUIET_LEVEL + SPIKE_AMP));
            spacing = 1 + {$random(seed)} % (2 * HOLDOFF);
         end else begin
            send_sample(SAMPLE_WIDTH'(QUIET_LEVEL + {$random(seed)} % 32));
            spacing--;
         end
      end
   endtask

   task automatic check_idle_outputs(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         check_value("out.valid", 32'h0, 32'(out.valid));
         check_value("out.pulse", 32'h0, 32'(out.pulse));
         check_value("pulse_count", 32'h0, 32'(pulse_count));
      end
   endtask

   // Outputs settle after the rising edge, so results are taken on the falling edge
   always @(negedge clk) begin : compare_results
      expect_t e;
      if (!rst && out.valid) begin
         result_count++;
         if (exp_q.size() == 0) begin
            $display("error: a result arrived while no sample was pending at %0t", $time);
            errors++;
         end else begin
            e = exp_q.pop_front();
            check_value("out.baseline", 32'(e.res.baseline), 32'(out.baseline));
            check_value("out.residual", 32'(e.res.residual), 32'(out.residual));
            check_value("out.pulse", 32'(e.res.pulse), 32'(out.pulse));
            check_value("pulse_count", 32'(e.count), 32'(pulse_count));
         end
      end
   end

   initial begin : watchdog
      #(TIMEOUT_NS * 1ns);
      $display("error: the run did not finish within %0d ns", TIMEOUT_NS);
      $display("errors: %0d", errors);
      $display("tests failed");
      $finish;
   end

   initial begin : stimulus
      rst = 1'b1;
      in = '{valid: 1'b0, data: '0};
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      check_idle_outputs(6);
      send_ramp();
      for (int i = 0; i < NUM_SAMPLES; i++) begin
         send_sample(random_sample());
      end
      for (int i = 0; i < NUM_SAMPLES; i++) begin
         if ({$random(seed)} % 100 < GAP_PCT) begin
            idle_cycles(1 + {$random(seed)} % MAX_GAP);
         end
         send_sample(random_sample());
      end
      send_spikes(NUM_SAMPLES / 2);
      // A reset between runs must empty the window and the pulse count
      drain_results();
      apply_reset();
      check_idle_outputs(3);
      send_ramp();
      send_spikes(NUM_SAMPLES / 4);
      drain_results();
      check_value("result_count", 32'(accepted_count), 32'(result_count));
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule
